//--- include/ili9341Tables.svh
/*
 * ILI9341 command tables with entries of {isData, byte}
 * init table assumes portrait mode (MADCTL 0x48) and RGB565 pixels
 * window covers the full 240 x 320 panel and ends with memory write
 * indices past the end of a table return a NOP command
 * included inside a module body, once per module
 */

function automatic ili9341Pkg::tftWord_t initWord(input ili9341Pkg::tableIndex_t index);
    case (index)
        // power control A
        5'd0:  initWord = {1'b0, 8'hCB};
        5'd1:  initWord = {1'b1, 8'h39};
        5'd2:  initWord = {1'b1, 8'h2C};
        5'd3:  initWord = {1'b1, 8'h00};
        5'd4:  initWord = {1'b1, 8'h34};
        5'd5:  initWord = {1'b1, 8'h02};
        // power control B
        5'd6:  initWord = {1'b0, 8'hCF};
        5'd7:  initWord = {1'b1, 8'h00};
        5'd8:  initWord = {1'b1, 8'hC1};
        5'd9:  initWord = {1'b1, 8'h30};
        // driver timing control A
        5'd10: initWord = {1'b0, 8'hE8};
        5'd11: initWord = {1'b1, 8'h85};
        5'd12: initWord = {1'b1, 8'h00};
        5'd13: initWord = {1'b1, 8'h78};
        // power control 1 and 2 and VCOM
        5'd14: initWord = {1'b0, 8'hC0};
        5'd15: initWord = {1'b1, 8'h23};
        5'd16: initWord = {1'b0, 8'hC1};
        5'd17: initWord = {1'b1, 8'h10};
        5'd18: initWord = {1'b0, 8'hC5};
        5'd19: initWord = {1'b1, 8'h3E};
        5'd20: initWord = {1'b1, 8'h28};
        // memory access control then 16 bit pixel format
        5'd21: initWord = {1'b0, 8'h36};
        5'd22: initWord = {1'b1, 8'h48};
        5'd23: initWord = {1'b0, 8'h3A};
        5'd24: initWord = {1'b1, 8'h55};
        // frame rate control
        5'd25: initWord = {1'b0, 8'hB1};
        5'd26: initWord = {1'b1, 8'h00};
        5'd27: initWord = {1'b1, 8'h18};
        // sleep out needs the wake delay afterwards
        5'd28: initWord = {1'b0, 8'h11};
        default: initWord = {1'b0, 8'h00};
    endcase
endfunction

function automatic ili9341Pkg::tftWord_t windowWord(input ili9341Pkg::tableIndex_t index);
    case (index)
        // column address set 0..239
        5'd0:  windowWord = {1'b0, 8'h2A};
        5'd1:  windowWord = {1'b1, 8'h00};
        5'd2:  windowWord = {1'b1, 8'h00};
        5'd3:  windowWord = {1'b1, 8'h00};
        5'd4:  windowWord = {1'b1, 8'hEF};
        // page address set 0..319
        5'd5:  windowWord = {1'b0, 8'h2B};
        5'd6:  windowWord = {1'b1, 8'h00};
        5'd7:  windowWord = {1'b1, 8'h00};
        5'd8:  windowWord = {1'b1, 8'h01};
        5'd9:  windowWord = {1'b1, 8'h3F};
        // memory write with the pixel bytes following
        5'd10: windowWord = {1'b0, 8'h2C};
        default: windowWord = {1'b0, 8'h00};
    endcase
endfunction

//--- hdl/ili9341Pkg.sv
/*
 * shared widths, timing constants and types of the ILI9341 controller
 * default delays assume a 50 MHz clock
 * write strobe counts must both be at least 1
 */

package ili9341Pkg;

    // one byte on the 8080-I bus
    typedef logic [7:0]  tftByte_t;
    // table entry with bit 8 set for data and clear for command
    typedef logic [8:0]  tftWord_t;
    // RGB565
    typedef logic [15:0] pixel_t;
    // 0 .. 76799
    typedef logic [16:0] pixelCount_t;
    typedef logic [4:0]  tableIndex_t;
    typedef logic [23:0] delay_t;

    localparam int NUM_SYNC_BYTES   = 3;
    localparam int NUM_INIT_WORDS   = 29;
    localparam int NUM_WINDOW_WORDS = 11;
    localparam int NUM_PIXELS       = 76800;

    localparam tftByte_t CMD_NOP        = 8'h00;
    localparam tftByte_t CMD_DISPLAY_ON = 8'h29;

    // write strobe shape in clock cycles
    localparam int WRITE_LOW_CYCLES  = 2;
    localparam int WRITE_HIGH_CYCLES = 2;

    // phase counter of the bus writer sized for the longer half
    typedef logic [$clog2(WRITE_LOW_CYCLES > WRITE_HIGH_CYCLES ?
                          WRITE_LOW_CYCLES : WRITE_HIGH_CYCLES):0] writePhase_t;

    // 10 ms, 120 ms and 5 ms at 50 MHz
    localparam delay_t DEFAULT_RESET_CYCLES = 24'd500000;
    localparam delay_t DEFAULT_WAKE_CYCLES  = 24'd6000000;
    localparam delay_t DEFAULT_SYNC_CYCLES  = 24'd250000;

    // which table the command ROM reads
    typedef enum logic [1:0] {
        TABLE_SYNC,
        TABLE_INIT,
        TABLE_DISPLAY_ON,
        TABLE_WINDOW
    } tableSel_t;

    typedef enum logic [3:0] {
        HOLD_RESET,
        RESET_WAIT,
        SYNC,
        SYNC_WAIT,
        INIT,
        SLEEP_WAIT,
        DISPLAY_ON,
        WINDOW,
        PIXELS
    } seqState_t;

    // one word from sequencer to bus writer
    typedef struct packed {
        logic     valid;
        tftByte_t data;
        logic     isData;
    } busReq_t;

    // panel pins where all but data are active low
    typedef struct packed {
        tftByte_t data;
        logic     chipSelect;
        logic     writeEnable;
        logic     dataCmd;
        logic     reset;
    } tftBus_t;

endpackage

//--- hdl/ili9341CmdRom.sv
/*
 * combinational command lookup for the sequencer
 * INIT and WINDOW entries come from the shared table header
 */
`timescale 1ns/1ps

module ili9341CmdRom
(
    input  ili9341Pkg::tableSel_t   tableSel,
    input  ili9341Pkg::tableIndex_t tableIndex,
    output ili9341Pkg::tftWord_t    cmdWord
);

    `include "ili9341Tables.svh"

    always_comb
    begin
        case (tableSel)
            // sync bytes are plain NOP commands
            ili9341Pkg::TABLE_SYNC:
            begin
                cmdWord = {1'b0, ili9341Pkg::CMD_NOP};
            end
            ili9341Pkg::TABLE_INIT:
            begin
                cmdWord = initWord(tableIndex);
            end
            // single command, index is ignored
            ili9341Pkg::TABLE_DISPLAY_ON:
            begin
                cmdWord = {1'b0, ili9341Pkg::CMD_DISPLAY_ON};
            end
            ili9341Pkg::TABLE_WINDOW:
            begin
                cmdWord = windowWord(tableIndex);
            end
            default:
            begin
                cmdWord = {1'b0, ili9341Pkg::CMD_NOP};
            end
        endcase
    end

endmodule

//--- hdl/ili9341BusWriter.sv
/*
 * one 8080-I write cycle per accepted word
 * write enable low for WRITE_LOW_CYCLES, then high for WRITE_HIGH_CYCLES
 * busReady returns one cycle after the high phase, panel samples on the rising edge
 */
`timescale 1ns/1ps

module ili9341BusWriter
(
    input  logic                 clk,
    input  logic                 reset,
    input  ili9341Pkg::busReq_t  busReq,
    output logic                 busReady,
    output ili9341Pkg::tftByte_t data,
    output logic                 writeEnable,
    output logic                 dataCmd
);

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_LOW,
        WR_HIGH
    } writeState_t;

    writeState_t             state;
    ili9341Pkg::writePhase_t phase;

    // last cycle of each half of the strobe
    logic lowDone;
    logic highDone;

    assign lowDone  = (phase == ili9341Pkg::writePhase_t'(ili9341Pkg::WRITE_LOW_CYCLES - 1));
    assign highDone = (phase == ili9341Pkg::writePhase_t'(ili9341Pkg::WRITE_HIGH_CYCLES - 1));

    // only idle takes a new word
    assign busReady = (state == WR_IDLE);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state       <= WR_IDLE;
            phase       <= '0;
            writeEnable <= 1'b1;
            data        <= '0;
            dataCmd     <= 1'b0;
        end
        else
        begin
            case (state)
                WR_IDLE:
                begin
                    if (busReq.valid)
                    begin
                        // capture word, it stays put through the whole strobe
                        data        <= busReq.data;
                        dataCmd     <= busReq.isData;
                        writeEnable <= 1'b0;
                        phase       <= '0;
                        state       <= WR_LOW;
                    end
                end
                WR_LOW:
                begin
                    if (lowDone)
                    begin
                        // rising edge, panel latches data here
                        writeEnable <= 1'b1;
                        phase       <= '0;
                        state       <= WR_HIGH;
                    end
                    else
                    begin
                        phase <= phase + 1'b1;
                    end
                end
                WR_HIGH:
                begin
                    // data held unchanged for the hold time
                    if (highDone)
                    begin
                        state <= WR_IDLE;
                    end
                    else
                    begin
                        phase <= phase + 1'b1;
                    end
                end
                default:
                begin
                    writeEnable <= 1'b1;
                    state       <= WR_IDLE;
                end
            endcase
        end
    end

endmodule

//--- hdl/ili9341Sequencer.sv
/*
 * power-up and frame sequencer of the ILI9341 controller
 * delay parameters count clock cycles and must be at least 2
 * wait states hold off until the last strobe has finished, then raise chip select
 * pixels go out high byte first, frame loop repeats forever
 */
`timescale 1ns/1ps

module ili9341Sequencer
#(
    parameter ili9341Pkg::delay_t resetCycles = ili9341Pkg::DEFAULT_RESET_CYCLES,
    parameter ili9341Pkg::delay_t wakeCycles  = ili9341Pkg::DEFAULT_WAKE_CYCLES,
    parameter ili9341Pkg::delay_t syncCycles  = ili9341Pkg::DEFAULT_SYNC_CYCLES
)
(
    input  logic                    clk,
    input  logic                    reset,
    input  ili9341Pkg::tftWord_t    cmdWord,
    output ili9341Pkg::tableSel_t   tableSel,
    output ili9341Pkg::tableIndex_t tableIndex,
    output ili9341Pkg::busReq_t     busReq,
    input  logic                    busReady,
    input  logic                    pixelValid,
    input  ili9341Pkg::pixel_t      pixel,
    output logic                    pixelReady,
    output logic                    panelReset,
    output logic                    chipSelect
);

    ili9341Pkg::seqState_t   state;
    ili9341Pkg::delay_t      delay;
    ili9341Pkg::pixelCount_t pixelCount;
    ili9341Pkg::pixel_t      pixelReg;

    // a latched pixel still has bytes to send
    logic pixelHeld;
    // high byte gone, low byte next
    logic sendLow;

    // per-state decode
    ili9341Pkg::tableIndex_t lastIndex;
    ili9341Pkg::seqState_t   stepNext;
    ili9341Pkg::delay_t      stepDelay;

    logic wordAccepted;
    logic pixelAccepted;

    assign wordAccepted  = busReq.valid && busReady;
    assign pixelReady    = (state == ili9341Pkg::PIXELS) && !pixelHeld;
    assign pixelAccepted = pixelValid && pixelReady;

    // table selection, last index and successor of each state
    always_comb
    begin
        tableSel  = ili9341Pkg::TABLE_SYNC;
        lastIndex = '0;
        stepNext  = ili9341Pkg::HOLD_RESET;
        stepDelay = ili9341Pkg::delay_t'(syncCycles - 1'b1);
        case (state)
            ili9341Pkg::HOLD_RESET:
            begin
                stepNext  = ili9341Pkg::RESET_WAIT;
                stepDelay = ili9341Pkg::delay_t'(wakeCycles - 1'b1);
            end
            ili9341Pkg::RESET_WAIT:
            begin
                stepNext = ili9341Pkg::SYNC;
            end
            ili9341Pkg::SYNC:
            begin
                lastIndex = ili9341Pkg::tableIndex_t'(ili9341Pkg::NUM_SYNC_BYTES - 1);
                stepNext  = ili9341Pkg::SYNC_WAIT;
            end
            ili9341Pkg::SYNC_WAIT:
            begin
                stepNext = ili9341Pkg::INIT;
            end
            ili9341Pkg::INIT:
            begin
                tableSel  = ili9341Pkg::TABLE_INIT;
                lastIndex = ili9341Pkg::tableIndex_t'(ili9341Pkg::NUM_INIT_WORDS - 1);
                stepNext  = ili9341Pkg::SLEEP_WAIT;
                stepDelay = ili9341Pkg::delay_t'(wakeCycles - 1'b1);
            end
            ili9341Pkg::SLEEP_WAIT:
            begin
                stepNext = ili9341Pkg::DISPLAY_ON;
            end
            ili9341Pkg::DISPLAY_ON:
            begin
                tableSel = ili9341Pkg::TABLE_DISPLAY_ON;
                stepNext = ili9341Pkg::WINDOW;
            end
            ili9341Pkg::WINDOW:
            begin
                tableSel  = ili9341Pkg::TABLE_WINDOW;
                lastIndex = ili9341Pkg::tableIndex_t'(ili9341Pkg::NUM_WINDOW_WORDS - 1);
                stepNext  = ili9341Pkg::PIXELS;
            end
            // end of frame goes back to the window
            ili9341Pkg::PIXELS:
            begin
                stepNext = ili9341Pkg::WINDOW;
            end
            default:
            begin
                stepNext = ili9341Pkg::HOLD_RESET;
            end
        endcase
    end

    // request to the bus writer, table word or a pixel byte
    always_comb
    begin
        busReq.valid  = 1'b0;
        busReq.data   = cmdWord[7:0];
        busReq.isData = cmdWord[8];
        case (state)
            ili9341Pkg::SYNC, ili9341Pkg::INIT, ili9341Pkg::DISPLAY_ON, ili9341Pkg::WINDOW:
            begin
                busReq.valid = 1'b1;
            end
            ili9341Pkg::PIXELS:
            begin
                busReq.valid  = pixelHeld;
                busReq.data   = sendLow ? pixelReg[7:0] : pixelReg[15:8];
                busReq.isData = 1'b1;
            end
            default:
            begin
                busReq.valid = 1'b0;
            end
        endcase
    end

    // pixel payload
    always_ff @(posedge clk)
    begin
        if (pixelAccepted)
        begin
            pixelReg <= pixel;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state      <= ili9341Pkg::HOLD_RESET;
            delay      <= ili9341Pkg::delay_t'(resetCycles - 1'b1);
            tableIndex <= '0;
            pixelCount <= '0;
            pixelHeld  <= 1'b0;
            sendLow    <= 1'b0;
            panelReset <= 1'b0;
            chipSelect <= 1'b1;
        end
        else
        begin
            case (state)
                ili9341Pkg::HOLD_RESET:
                begin
                    // panel reset pin low for resetCycles
                    if (delay == '0)
                    begin
                        panelReset <= 1'b1;
                        delay      <= stepDelay;
                        state      <= stepNext;
                    end
                    else
                    begin
                        delay <= delay - 1'b1;
                    end
                end
                ili9341Pkg::RESET_WAIT, ili9341Pkg::SYNC_WAIT, ili9341Pkg::SLEEP_WAIT:
                begin
                    // nothing moves while the last strobe is still on the bus
                    if (busReady)
                    begin
                        chipSelect <= 1'b1;
                        if (delay == '0)
                        begin
                            chipSelect <= 1'b0;
                            state      <= stepNext;
                        end
                        else
                        begin
                            delay <= delay - 1'b1;
                        end
                    end
                end
                ili9341Pkg::PIXELS:
                begin
                    if (pixelAccepted)
                    begin
                        pixelHeld <= 1'b1;
                        sendLow   <= 1'b0;
                    end
                    else if (wordAccepted && !sendLow)
                    begin
                        sendLow <= 1'b1;
                    end
                    else if (wordAccepted)
                    begin
                        // low byte taken, pixel done
                        pixelHeld <= 1'b0;
                        sendLow   <= 1'b0;
                        if (pixelCount == ili9341Pkg::pixelCount_t'(ili9341Pkg::NUM_PIXELS - 1))
                        begin
                            pixelCount <= '0;
                            state      <= stepNext;
                        end
                        else
                        begin
                            pixelCount <= pixelCount + 1'b1;
                        end
                    end
                end
                // table states, index steps on each accepted word
                default:
                begin
                    if (wordAccepted)
                    begin
                        if (tableIndex == lastIndex)
                        begin
                            tableIndex <= '0;
                            delay      <= stepDelay;
                            state      <= stepNext;
                        end
                        else
                        begin
                            tableIndex <= tableIndex + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

endmodule

//--- hdl/ili9341Ctrl.sv
/*
 * ILI9341 controller top, 8080-I parallel bus, single clock
 * pixels arrive on a valid/ready stream, 76800 per frame
 * delay parameters are in clock cycles
 */
`timescale 1ns/1ps

module ili9341Ctrl
#(
    parameter ili9341Pkg::delay_t resetCycles = ili9341Pkg::DEFAULT_RESET_CYCLES,
    parameter ili9341Pkg::delay_t wakeCycles  = ili9341Pkg::DEFAULT_WAKE_CYCLES,
    parameter ili9341Pkg::delay_t syncCycles  = ili9341Pkg::DEFAULT_SYNC_CYCLES
)
(
    input  logic                clk,
    input  logic                reset,
    input  logic                pixelValid,
    input  ili9341Pkg::pixel_t  pixel,
    output logic                pixelReady,
    output ili9341Pkg::tftBus_t tftBus
);

    ili9341Pkg::tftWord_t    cmdWord;
    ili9341Pkg::tableSel_t   tableSel;
    ili9341Pkg::tableIndex_t tableIndex;
    ili9341Pkg::busReq_t     busReq;
    logic                    busReady;
    logic                    panelReset;
    logic                    chipSelect;
    ili9341Pkg::tftByte_t    busData;
    logic                    writeEnable;
    logic                    dataCmd;

    ili9341Sequencer #(
        .resetCycles (resetCycles),
        .wakeCycles  (wakeCycles),
        .syncCycles  (syncCycles)
    ) sequencer (
        .clk        (clk),
        .reset      (reset),
        .cmdWord    (cmdWord),
        .tableSel   (tableSel),
        .tableIndex (tableIndex),
        .busReq     (busReq),
        .busReady   (busReady),
        .pixelValid (pixelValid),
        .pixel      (pixel),
        .pixelReady (pixelReady),
        .panelReset (panelReset),
        .chipSelect (chipSelect)
    );

    ili9341CmdRom cmdRom (
        .tableSel   (tableSel),
        .tableIndex (tableIndex),
        .cmdWord    (cmdWord)
    );

    ili9341BusWriter busWriter (
        .clk         (clk),
        .reset       (reset),
        .busReq      (busReq),
        .busReady    (busReady),
        .data        (busData),
        .writeEnable (writeEnable),
        .dataCmd     (dataCmd)
    );

    // panel pins, reset and chip select from sequencer, strobe side from writer
    assign tftBus = '{data:        busData,
                      chipSelect:  chipSelect,
                      writeEnable: writeEnable,
                      dataCmd:     dataCmd,
                      reset:       panelReset};

endmodule

//--- sim/ili9341Tb.sv
/*
 * testbench for the ILI9341 controller with short power-up delays
 * runs one full frame and the start of the next in roughly 800k clock cycles
 * bus is sampled and inputs are driven on the falling clock edge
 */
`timescale 1ns/1ps

module ili9341Tb;

    `include "ili9341Tables.svh"

    localparam ili9341Pkg::delay_t RESET_CYCLES = 24'd40;
    localparam ili9341Pkg::delay_t WAKE_CYCLES  = 24'd60;
    localparam ili9341Pkg::delay_t SYNC_CYCLES  = 24'd20;

    // sync bytes, init table and display on
    localparam int NUM_STARTUP     = ili9341Pkg::NUM_SYNC_BYTES + ili9341Pkg::NUM_INIT_WORDS + 1;
    localparam int NUM_COMMANDS    = NUM_STARTUP + ili9341Pkg::NUM_WINDOW_WORDS;
    localparam int NUM_FRAME_BYTES = 2 * ili9341Pkg::NUM_PIXELS;
    // pixel bytes of the second frame seen before stopping
    localparam int WRAP_BYTES   = 64;
    localparam int RUN_TIMEOUT  = 2000000;
    localparam int IDLE_TIMEOUT = 2000;

    logic                clk;
    logic                reset;
    logic                pixelValid;
    ili9341Pkg::pixel_t  pixel;
    logic                pixelReady;
    ili9341Pkg::tftBus_t tftBus;

    logic [31:0]          lfsr;
    // expected pixel bytes in bus order
    ili9341Pkg::tftByte_t byteQueue[$];
    bit                   monitorOn;
    bit                   offerTaken;

    // strobe tracking
    logic                 prevWe;
    ili9341Pkg::tftByte_t strobeData;
    logic                 strobeFlag;
    int                   lowCount;
    int                   highCount;
    bit                   seenStrobe;
    int                   strobeTotal;

    // position in the expected stream
    int                      cmdPos;
    bit                      inPixels;
    bit                      startupDone;
    int                      pixelBytes;
    int                      frameCount;
    ili9341Pkg::pixelCount_t framePixels;
    bit                      runDone;

    ili9341Ctrl #(
        .resetCycles (RESET_CYCLES),
        .wakeCycles  (WAKE_CYCLES),
        .syncCycles  (SYNC_CYCLES)
    ) uut (
        .clk        (clk),
        .reset      (reset),
        .pixelValid (pixelValid),
        .pixel      (pixel),
        .pixelReady (pixelReady),
        .tftBus     (tftBus)
    );

    // 20 ns period
    always #10 clk = ~clk;

    // 32 bit fibonacci lfsr with taps 32 22 2 1 stepped once per bit taken
    function automatic logic [15:0] randomBits(input int count);
        logic        feedback;
        logic [15:0] result;
        result = '0;
        for (int i = 0; i < count; i++)
        begin
            feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr     = {lfsr[30:0], feedback};
            result   = {result[14:0], feedback};
        end
        randomBits = result;
    endfunction

    // expected command stream of startup words then the window table
    function automatic ili9341Pkg::tftWord_t expectedCommand(input int pos);
        if (pos < ili9341Pkg::NUM_SYNC_BYTES)
            expectedCommand = {1'b0, 8'h00};
        else if (pos < NUM_STARTUP - 1)
            expectedCommand = initWord(
                ili9341Pkg::tableIndex_t'(pos - ili9341Pkg::NUM_SYNC_BYTES));
        else if (pos == NUM_STARTUP - 1)
            expectedCommand = {1'b0, 8'h29};
        else
            expectedCommand = windowWord(ili9341Pkg::tableIndex_t'(pos - NUM_STARTUP));
    endfunction

    task automatic abortRun();
        $display("Something failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic reportProblem(input string what);
        $display("%s", what);
        abortRun();
    endtask

    task automatic checkByte(input string name, input ili9341Pkg::tftByte_t expected,
                             input ili9341Pkg::tftByte_t actual);
        if (actual !== expected)
        begin
            $display("** Error %s: expected %02h, actual %02h", name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("** Error %s: expected %b, actual %b", name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkCount(input string name, input ili9341Pkg::pixelCount_t expected,
                              input ili9341Pkg::pixelCount_t actual);
        if (actual !== expected)
        begin
            $display("** Error %s: expected %0d, actual %0d", name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkCycles(input string name, input ili9341Pkg::delay_t expected,
                               input ili9341Pkg::delay_t actual);
        if (actual !== expected)
        begin
            $display("** Error %s: expected %0d, actual %0d", name, expected, actual);
            abortRun();
        end
    endtask

    // pins while the panel is held in reset
    task automatic checkResetPins(input string phase);
        checkFlag({phase, " panel reset"}, 1'b0, tftBus.reset);
        checkFlag({phase, " chip select"}, 1'b1, tftBus.chipSelect);
        checkFlag({phase, " write enable"}, 1'b1, tftBus.writeEnable);
        checkFlag({phase, " pixel ready"}, 1'b0, pixelReady);
    endtask

    // compare one byte taken by the panel against the expected stream
    task automatic checkStrobe(input ili9341Pkg::tftByte_t data, input logic flag);
        ili9341Pkg::tftWord_t expected;
        if (!inPixels)
        begin
            expected = expectedCommand(cmdPos);
            checkByte($sformatf("command word %0d byte", cmdPos), expected[7:0], data);
            checkFlag($sformatf("command word %0d data flag", cmdPos), expected[8], flag);
            cmdPos++;
            if (cmdPos == NUM_STARTUP)
                startupDone = 1'b1;
            if (cmdPos == NUM_COMMANDS)
            begin
                inPixels   = 1'b1;
                pixelBytes = 0;
            end
        end
        else
        begin
            if (byteQueue.size() == 0)
                reportProblem("pixel byte on the bus that was never accepted");
            checkByte($sformatf("frame %0d pixel byte %0d", frameCount, pixelBytes),
                      byteQueue.pop_front(), data);
            checkFlag($sformatf("frame %0d pixel byte %0d data flag", frameCount, pixelBytes),
                      1'b1, flag);
            pixelBytes++;
            if (frameCount > 0 && pixelBytes == WRAP_BYTES)
                runDone = 1'b1;
            if (pixelBytes == NUM_FRAME_BYTES)
            begin
                // window table comes again after a full frame
                checkCount($sformatf("frame %0d pixels accepted", frameCount),
                           ili9341Pkg::pixelCount_t'(ili9341Pkg::NUM_PIXELS), framePixels);
                framePixels = '0;
                frameCount++;
                inPixels    = 1'b0;
                cmdPos      = NUM_STARTUP;
            end
        end
    endtask

    // strobe shape and capture on the rising edge of write enable
    task automatic sampleBus();
        if (startupDone && tftBus.chipSelect)
            reportProblem("chip select went high after startup");
        if (prevWe && !tftBus.writeEnable)
        begin
            if (tftBus.chipSelect)
                reportProblem("write strobe started while chip select was high");
            if (seenStrobe && highCount < ili9341Pkg::WRITE_HIGH_CYCLES)
                reportProblem($sformatf("write enable high for only %0d cycles", highCount));
            // no strobe without a pending pixel byte
            if (inPixels && byteQueue.size() == 0)
                reportProblem("write strobe started with no accepted pixel pending");
            strobeData = tftBus.data;
            strobeFlag = tftBus.dataCmd;
            lowCount   = 1;
        end
        else if (!prevWe && !tftBus.writeEnable)
        begin
            lowCount++;
            if (tftBus.chipSelect)
                reportProblem("chip select high during a write strobe");
            if (tftBus.data !== strobeData || tftBus.dataCmd !== strobeFlag)
                reportProblem("data or data/command changed while write enable was low");
        end
        else if (!prevWe && tftBus.writeEnable)
        begin
            checkCycles("write enable low time", ili9341Pkg::delay_t'(ili9341Pkg::WRITE_LOW_CYCLES),
                        ili9341Pkg::delay_t'(lowCount));
            checkByte("data held to the rising edge", strobeData, tftBus.data);
            checkStrobe(tftBus.data, tftBus.dataCmd);
            highCount  = 1;
            seenStrobe = 1'b1;
            strobeTotal++;
        end
        else
        begin
            highCount++;
        end
        prevWe = tftBus.writeEnable;
    endtask

    // valid/ready source holding each offer until it is taken
    task automatic drivePixel();
        logic [1:0] roll;
        if (offerTaken || !pixelValid)
        begin
            roll       = 2'(randomBits(2));
            pixelValid = (roll != 2'b00);
            pixel      = randomBits(16);
        end
        // pixelReady does not depend on pixelValid so the next edge is known here
        offerTaken = pixelValid && pixelReady;
        if (offerTaken)
        begin
            byteQueue.push_back(pixel[15:8]);
            byteQueue.push_back(pixel[7:0]);
            framePixels = framePixels + 1'b1;
        end
    endtask

    always @(negedge clk)
    begin
        if (monitorOn)
        begin
            sampleBus();
            drivePixel();
        end
    end

    initial
    begin
        int cycles;
        int idle;
        int lastTotal;
        bit rose;
        clk         = 1'b0;
        reset       = 1'b1;
        pixelValid  = 1'b0;
        pixel       = '0;
        lfsr        = 32'h189a;
        prevWe      = 1'b1;
        framePixels = '0;
        repeat (5)
        begin
            @(negedge clk);
            checkResetPins("during reset");
            checkByte("data during reset", 8'h00, tftBus.data);
            checkFlag("data/command during reset", 1'b0, tftBus.dataCmd);
        end
        reset = 1'b0;
        @(posedge clk);
        monitorOn = 1'b1;

        // panel reset length counted from the release of reset
        cycles = 0;
        rose   = 1'b0;
        while (!rose)
        begin
            @(negedge clk);
            cycles++;
            if (tftBus.reset === 1'b1)
                rose = 1'b1;
            else
            begin
                checkResetPins("after reset");
                if (cycles > RESET_CYCLES + 10)
                    reportProblem("panel reset did not rise");
            end
        end
        checkCycles("panel reset low time", RESET_CYCLES, ili9341Pkg::delay_t'(cycles));

        // run through a frame and into the next one
        cycles    = 0;
        idle      = 0;
        lastTotal = 0;
        while (!runDone)
        begin
            @(posedge clk);
            cycles++;
            if (strobeTotal != lastTotal)
            begin
                lastTotal = strobeTotal;
                idle      = 0;
            end
            else
                idle++;
            if (idle > IDLE_TIMEOUT)
                reportProblem("no write strobe for too long, controller stalled");
            if (cycles > RUN_TIMEOUT)
                reportProblem("frame did not wrap within the time limit");
        end
        $display("Everything OK");
        $finish;
    end

endmodule

//--- ili9341Ctrl.f
+incdir+include
hdl/ili9341Pkg.sv
hdl/ili9341CmdRom.sv
hdl/ili9341BusWriter.sv
hdl/ili9341Sequencer.sv
hdl/ili9341Ctrl.sv
sim/ili9341Tb.sv
